// File: include/phold_defs.svh
`ifndef PHOLD_DEFS_SVH
`define PHOLD_DEFS_SVH

// Engine sizing
`define PHOLD_NUM_CORE  4
`define PHOLD_CORE_W    2
`define PHOLD_NUM_LP    16
`define PHOLD_LP_W      4
`define PHOLD_TIME_W    16

// Event queue
`define PHOLD_Q_DEPTH   32
`define PHOLD_CNT_W     6

// Event generation
`define PHOLD_SEED_RST  16'hACE1
`define PHOLD_LFSR_MASK 16'hB400
`define PHOLD_GEN_STEPS 8           // Galois steps per generated event

`endif

// File: phold_engine.f
+incdir+include
src/phold_pkg.sv
src/rr_arbiter.sv
src/event_queue.sv
src/phold_cfg_regs.sv
src/phold_core.sv
src/phold_engine.sv
verif/phold_checker.sv
verif/phold_tb.sv

// File: src/event_queue.sv
`default_nettype none

`include "phold_defs.svh"

module event_queue (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      clear,
	input  wire                      enq,
	input  wire  [`PHOLD_LP_W-1:0]   enq_lp,
	input  wire  [`PHOLD_TIME_W-1:0] enq_time,
	input  wire                      deq,
	output logic [`PHOLD_LP_W-1:0]   head_lp,
	output logic [`PHOLD_TIME_W-1:0] head_time,
	output logic                     empty,
	output logic                     full,
	output logic [`PHOLD_CNT_W-1:0]  count
);

	localparam int DEPTH = `PHOLD_Q_DEPTH;

	logic [`PHOLD_LP_W-1:0]   q_lp    [DEPTH];
	logic [`PHOLD_TIME_W-1:0] q_time  [DEPTH];
	logic [`PHOLD_LP_W-1:0]   sh_lp   [DEPTH];  // After the head leaves
	logic [`PHOLD_TIME_W-1:0] sh_time [DEPTH];
	logic [`PHOLD_LP_W-1:0]   nx_lp   [DEPTH];  // After the insert
	logic [`PHOLD_TIME_W-1:0] nx_time [DEPTH];
	logic [`PHOLD_CNT_W-1:0]  sh_cnt;
	logic [`PHOLD_CNT_W-1:0]  nx_cnt;
	logic [`PHOLD_CNT_W-1:0]  ins_pos;

	always_comb begin
		for (int i = 0; i < DEPTH - 1; i++) begin
			sh_lp[i]   = deq ? q_lp[i + 1] : q_lp[i];
			sh_time[i] = deq ? q_time[i + 1] : q_time[i];
		end
		sh_lp[DEPTH - 1]   = q_lp[DEPTH - 1];   // Slot is invalid after a dequeue
		sh_time[DEPTH - 1] = q_time[DEPTH - 1];
		sh_cnt = count - `PHOLD_CNT_W'(deq);

		// Insert after every entry with an equal or earlier time
		ins_pos = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (i < sh_cnt && sh_time[i] <= enq_time) begin
				ins_pos = `PHOLD_CNT_W'(i + 1);
			end
		end

		nx_lp[0]   = (enq && ins_pos == '0) ? enq_lp : sh_lp[0];
		nx_time[0] = (enq && ins_pos == '0) ? enq_time : sh_time[0];
		for (int i = 1; i < DEPTH; i++) begin
			if (!enq || i < ins_pos) begin
				nx_lp[i]   = sh_lp[i];
				nx_time[i] = sh_time[i];
			end else if (i == ins_pos) begin
				nx_lp[i]   = enq_lp;
				nx_time[i] = enq_time;
			end else begin
				nx_lp[i]   = sh_lp[i - 1];
				nx_time[i] = sh_time[i - 1];
			end
		end
		nx_cnt = sh_cnt + `PHOLD_CNT_W'(enq);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else begin
			count <= nx_cnt;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			q_lp[i]   <= nx_lp[i];
			q_time[i] <= nx_time[i];
		end
	end

	assign head_lp   = q_lp[0];
	assign head_time = q_time[0];
	assign empty     = (count == '0);
	assign full      = (count == `PHOLD_CNT_W'(DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(enq && full && !deq && !clear));

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(deq && empty && !clear));

endmodule

`default_nettype wire

// File: src/phold_cfg_regs.sv
`default_nettype none

`include "phold_defs.svh"

module phold_cfg_regs import phold_pkg::*; (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     cfg_wr,
	input  wire  [1:0]              cfg_addr,
	input  wire  [15:0]             cfg_wdata,
	input  wire                     busy,
	output logic [15:0]             cfg_rdata,
	output logic                    start,
	output logic [`PHOLD_TIME_W-1:0] end_time,
	output logic [15:0]             seed
);

	cfg_reg_t reg_sel;

	assign reg_sel = cfg_reg_t'(cfg_addr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start    <= 1'b0;
			end_time <= '0;
			seed     <= `PHOLD_SEED_RST;
		end else begin
			// Back-to-back start writes yield a single pulse
			start <= cfg_wr && (reg_sel == REG_CTRL) && cfg_wdata[0] && !busy && !start;
			if (cfg_wr && (reg_sel == REG_END_TIME)) begin
				end_time <= cfg_wdata;
			end
			if (cfg_wr && (reg_sel == REG_SEED)) begin
				seed <= cfg_wdata;
			end
		end
	end

	always_comb begin
		cfg_rdata = '0;
		case (reg_sel)
			REG_END_TIME: cfg_rdata = end_time;
			REG_SEED:     cfg_rdata = seed;
			REG_STATUS:   cfg_rdata[0] = busy;
			default:      cfg_rdata = '0;       // Control reads as zero
		endcase
	end

	// The engine leaves idle only on the edge after the pulse
	a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(start && busy));

endmodule

`default_nettype wire

// File: src/phold_core.sv
`default_nettype none

`include "phold_defs.svh"

module phold_core import phold_pkg::*; (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      event_valid,
	input  wire  [`PHOLD_LP_W-1:0]   evt_lp,
	input  wire  [`PHOLD_TIME_W-1:0] evt_time,
	input  wire  [15:0]              seed,
	input  wire                      ack,
	output logic                     idle,
	output logic [`PHOLD_TIME_W-1:0] busy_time,
	output logic                     busy,
	output logic                     gen_vld,
	output logic [`PHOLD_LP_W-1:0]   gen_lp,
	output logic [`PHOLD_TIME_W-1:0] gen_time
);

	localparam int STEP_W = $clog2(`PHOLD_GEN_STEPS + 1);

	core_state_t              state;
	logic [STEP_W-1:0]        step_cnt;
	logic [15:0]              lfsr;
	logic [15:0]              lfsr_load;
	logic [`PHOLD_TIME_W-1:0] ev_time;
	logic                     last_step;

	function automatic logic [15:0] galois_step(input logic [15:0] v);
		galois_step = v[0] ? ((v >> 1) ^ `PHOLD_LFSR_MASK) : (v >> 1);
	endfunction

	// Seed mixed with the event, never the all-zero lock state
	always_comb begin
		lfsr_load = seed ^ evt_time ^ {evt_lp, 12'h000};
		if (lfsr_load == '0) begin
			lfsr_load = seed;
		end
	end

	assign last_step = (step_cnt == STEP_W'(`PHOLD_GEN_STEPS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= CORE_IDLE;
			step_cnt <= '0;
		end else begin
			case (state)
				CORE_IDLE: if (event_valid) begin
					state    <= CORE_GEN;
					step_cnt <= '0;
				end
				CORE_GEN: if (last_step) begin
					state <= CORE_DONE;          // One extra cycle after the last step
				end else begin
					step_cnt <= step_cnt + 1'b1;
				end
				CORE_DONE: if (ack) begin
					state <= CORE_IDLE;
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CORE_IDLE && event_valid) begin
			ev_time <= evt_time;
			lfsr    <= lfsr_load;
		end else if (state == CORE_GEN && !last_step) begin
			lfsr <= galois_step(lfsr);
		end
	end

	assign idle      = (state == CORE_IDLE);
	assign busy      = !idle;
	assign busy_time = busy ? ev_time : '1;  // Neutral for the minimum
	assign gen_vld   = (state == CORE_DONE);
	assign gen_lp    = lfsr[7:4];
	assign gen_time  = ev_time + `PHOLD_TIME_W'(lfsr[3:0]) + `PHOLD_TIME_W'(1);

	// Dispatch lands only on an idle core and yields a request after fixed latency
	a_gen_latency: assert property (@(posedge clk) disable iff (!rst_n)
		event_valid |-> idle ##(`PHOLD_GEN_STEPS + 2) $rose(gen_vld));

endmodule

`default_nettype wire

// File: src/phold_engine.sv
`default_nettype none

`include "phold_defs.svh"

module phold_engine import phold_pkg::*; (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      cfg_wr,
	input  wire  [1:0]               cfg_addr,
	input  wire  [15:0]              cfg_wdata,
	output logic [15:0]              cfg_rdata,
	output logic [`PHOLD_TIME_W-1:0] gvt,
	output logic                     rtn_vld,
	output logic                     disp_vld,
	output logic [`PHOLD_CORE_W-1:0] disp_core,
	output logic [`PHOLD_LP_W-1:0]   disp_lp,
	output logic [`PHOLD_TIME_W-1:0] disp_time,
	output logic                     commit_vld,
	output logic [`PHOLD_CORE_W-1:0] commit_core,
	output logic [`PHOLD_LP_W-1:0]   commit_lp,
	output logic [`PHOLD_TIME_W-1:0] commit_time
);

	localparam int NC = `PHOLD_NUM_CORE;

	engine_state_t            state;
	logic                     busy;
	logic                     start;
	logic [`PHOLD_TIME_W-1:0] end_time;
	logic [15:0]              seed;
	logic [`PHOLD_LP_W:0]     init_cnt;     // 0 clears, 1..NUM_LP enqueue
	logic                     init_enq;
	logic                     q_clear;
	logic                     q_enq;
	logic [`PHOLD_LP_W-1:0]   q_enq_lp;
	logic [`PHOLD_TIME_W-1:0] q_enq_time;
	logic [`PHOLD_LP_W-1:0]   head_lp;
	logic [`PHOLD_TIME_W-1:0] head_time;
	logic                     q_empty;
	logic                     q_full;
	logic [`PHOLD_CNT_W-1:0]  q_count;
	logic [NC-1:0]            disp_gnt;
	logic                     disp_any;
	logic [NC-1:0]            commit_gnt;
	logic                     commit_any;
	logic [NC-1:0]            core_idle;
	logic [NC-1:0]            core_busy;
	logic [NC-1:0]            core_gen_vld;
	logic [NC-1:0]            core_event_valid;
	logic [NC-1:0]            core_ack;
	logic [`PHOLD_TIME_W-1:0] core_btime    [NC];
	logic [`PHOLD_LP_W-1:0]   core_gen_lp   [NC];
	logic [`PHOLD_TIME_W-1:0] core_gen_time [NC];
	logic [`PHOLD_TIME_W-1:0] gvt_min;
	logic                     gvt_ok;
	logic [`PHOLD_TIME_W-1:0] gvt_nxt;
	logic                     all_idle;

	assign busy     = (state != ST_IDLE);
	assign all_idle = &core_idle;

	phold_cfg_regs u_cfg (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.busy      (busy),
		.cfg_rdata (cfg_rdata),
		.start     (start),
		.end_time  (end_time),
		.seed      (seed)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			init_cnt <= '0;
			gvt      <= '0;
		end else begin
			case (state)
				ST_IDLE: if (start) begin
					state    <= ST_INIT;
					init_cnt <= '0;
					gvt      <= '0;
				end
				ST_INIT: if (init_cnt == (`PHOLD_LP_W + 1)'(`PHOLD_NUM_LP)) begin
					state <= ST_RUNNING;
				end else begin
					init_cnt <= init_cnt + 1'b1;
				end
				ST_RUNNING: begin
					gvt <= gvt_nxt;
					if (gvt > end_time) begin
						state <= ST_FINISHED;
					end
				end
				ST_FINISHED: if (all_idle) begin
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign rtn_vld = (state == ST_FINISHED) && all_idle;

	// Enqueue source is the initial fill or the granted commit
	assign q_clear    = (state == ST_INIT) && (init_cnt == '0);
	assign init_enq   = (state == ST_INIT) && (init_cnt != '0);
	assign q_enq      = init_enq || commit_vld;
	assign q_enq_lp   = init_enq ? `PHOLD_LP_W'(init_cnt - 1'b1) : commit_lp;
	assign q_enq_time = init_enq ? '0 : commit_time;

	event_queue u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (q_clear),
		.enq       (q_enq),
		.enq_lp    (q_enq_lp),
		.enq_time  (q_enq_time),
		.deq       (disp_vld),
		.head_lp   (head_lp),
		.head_time (head_time),
		.empty     (q_empty),
		.full      (q_full),
		.count     (q_count)
	);

	// Commit wins over dispatch
	assign commit_vld = commit_any && (state == ST_RUNNING || state == ST_FINISHED);
	assign disp_vld   = (state == ST_RUNNING) && !q_empty && disp_any && !commit_vld;
	assign disp_lp    = head_lp;
	assign disp_time  = head_time;
	assign commit_lp   = core_gen_lp[commit_core];
	assign commit_time = core_gen_time[commit_core];

	rr_arbiter disp_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_idle),
		.adv     (disp_vld),
		.gnt     (disp_gnt),
		.gnt_idx (disp_core),
		.any     (disp_any)
	);

	rr_arbiter commit_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_gen_vld),
		.adv     (commit_vld),
		.gnt     (commit_gnt),
		.gnt_idx (commit_core),
		.any     (commit_any)
	);

	for (genvar c = 0; c < NC; c++) begin : gen_core
		assign core_event_valid[c] = disp_vld && disp_gnt[c];
		assign core_ack[c]         = commit_vld && commit_gnt[c];

		phold_core u_core (
			.clk         (clk),
			.rst_n       (rst_n),
			.event_valid (core_event_valid[c]),
			.evt_lp      (head_lp),
			.evt_time    (head_time),
			.seed        (seed),
			.ack         (core_ack[c]),
			.idle        (core_idle[c]),
			.busy_time   (core_btime[c]),
			.busy        (core_busy[c]),
			.gen_vld     (core_gen_vld[c]),
			.gen_lp      (core_gen_lp[c]),
			.gen_time    (core_gen_time[c])
		);
	end

	// Earliest pending time over the queue head and every busy core
	always_comb begin
		gvt_min = '1;
		gvt_ok  = 1'b0;
		if (!q_empty) begin
			gvt_min = head_time;
			gvt_ok  = 1'b1;
		end
		for (int c = 0; c < NC; c++) begin
			if (core_busy[c]) begin
				gvt_ok = 1'b1;
				if (core_btime[c] < gvt_min) begin
					gvt_min = core_btime[c];
				end
			end
		end
		gvt_nxt = gvt_ok ? gvt_min : gvt;
	end

	// New events always land later than the event that made them
	a_gvt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_RUNNING) |=> (gvt >= $past(gvt)));

	// The queue never holds more events than there are LPs
	a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
		!q_full && (q_count <= `PHOLD_CNT_W'(`PHOLD_NUM_LP)));

endmodule

`default_nettype wire

// File: src/phold_pkg.sv
`default_nettype none

package phold_pkg;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INIT,                        // Queue clear plus one event per LP
		ST_RUNNING,
		ST_FINISHED                     // Draining the cores
	} engine_state_t;

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_GEN,                       // Stepping the LFSR
		CORE_DONE                       // New event waits for commit
	} core_state_t;

	typedef enum logic [1:0] {
		REG_CTRL     = 2'd0,            // Bit 0 starts a run
		REG_END_TIME = 2'd1,
		REG_SEED     = 2'd2,
		REG_STATUS   = 2'd3             // Bit 0 is busy
	} cfg_reg_t;

endpackage

`default_nettype wire

// File: src/rr_arbiter.sv
`default_nettype none

`include "phold_defs.svh"

module rr_arbiter #(
	parameter int N     = `PHOLD_NUM_CORE,
	parameter int IDX_W = `PHOLD_CORE_W
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire  [N-1:0]     req,
	input  wire              adv,
	output logic [N-1:0]     gnt,
	output logic [IDX_W-1:0] gnt_idx,
	output logic             any
);

	logic [IDX_W-1:0] ptr;              // Highest priority requester

	always_comb begin
		logic [IDX_W-1:0] cand;
		gnt     = '0;
		gnt_idx = '0;
		any     = 1'b0;
		for (int i = 0; i < N; i++) begin
			cand = IDX_W'((int'(ptr) + i) % N);
			if (!any && req[cand]) begin
				any        = 1'b1;
				gnt_idx    = cand;
				gnt[cand]  = 1'b1;
			end
		end
	end

	// Rotate only when the grant is used
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (adv && any) begin
			ptr <= (int'(gnt_idx) == N - 1) ? '0 : gnt_idx + 1'b1;
		end
	end

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

`default_nettype wire

// File: verif/phold_checker.sv
`default_nettype none

`include "phold_defs.svh"

module phold_checker import phold_pkg::*; (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      cfg_wr,
	input  wire  [1:0]               cfg_addr,
	input  wire  [15:0]              cfg_wdata,
	input  wire  [`PHOLD_TIME_W-1:0] gvt,
	input  wire                      rtn_vld,
	input  wire                      disp_vld,
	input  wire  [`PHOLD_CORE_W-1:0] disp_core,
	input  wire  [`PHOLD_LP_W-1:0]   disp_lp,
	input  wire  [`PHOLD_TIME_W-1:0] disp_time,
	input  wire                      commit_vld,
	input  wire  [`PHOLD_CORE_W-1:0] commit_core,
	input  wire  [`PHOLD_LP_W-1:0]   commit_lp,
	input  wire  [`PHOLD_TIME_W-1:0] commit_time,
	output int                       err_count,
	output int                       disp_total,
	output int                       commit_total
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int EW = `PHOLD_LP_W + `PHOLD_TIME_W;   // Event is {lp, time}

	logic [15:0]              cur_seed;
	logic [`PHOLD_TIME_W-1:0] cur_end;
	logic                     running;
	logic                     gvt_armed;              // Set by the first dispatch of a run
	logic                     gvt_passed;
	logic [`PHOLD_TIME_W-1:0] last_gvt;
	int                       run_disp;
	int                       run_commit;
	logic                     pending   [`PHOLD_NUM_CORE];
	logic [`PHOLD_LP_W-1:0]   held_lp   [`PHOLD_NUM_CORE];
	logic [`PHOLD_TIME_W-1:0] held_time [`PHOLD_NUM_CORE];
	logic [EW-1:0]            model_q[$];

	function automatic logic [EW-1:0] next_event(input logic [15:0] s,
		input logic [`PHOLD_LP_W-1:0] lp, input logic [`PHOLD_TIME_W-1:0] t);
		logic [15:0] v;
		v = s ^ t ^ {lp, 12'h000};
		if (v == 16'h0000) begin
			v = s;
		end
		for (int i = 0; i < `PHOLD_GEN_STEPS; i++) begin
			v = v[0] ? ((v >> 1) ^ `PHOLD_LFSR_MASK) : (v >> 1);
		end
		next_event = {v[7:4], t + `PHOLD_TIME_W'(v[3:0]) + `PHOLD_TIME_W'(1)};
	endfunction

	function automatic logic [`PHOLD_TIME_W-1:0] earliest_time();
		logic [`PHOLD_TIME_W-1:0] m;
		m = '1;
		foreach (model_q[i]) begin
			if (model_q[i][`PHOLD_TIME_W-1:0] < m) begin
				m = model_q[i][`PHOLD_TIME_W-1:0];
			end
		end
		return m;
	endfunction

	task automatic flag_error(input string msg);
		err_count++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// Fresh run: one event at time 0 per LP
	task automatic begin_run();
		running    = 1'b1;
		gvt_armed  = 1'b0;
		gvt_passed = 1'b0;
		run_disp   = 0;
		run_commit = 0;
		model_q.delete();
		for (int lp = 0; lp < `PHOLD_NUM_LP; lp++) begin
			model_q.push_back({`PHOLD_LP_W'(lp), `PHOLD_TIME_W'(0)});
		end
		for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
			pending[c] = 1'b0;
		end
	endtask

	// Outputs are sampled mid cycle, where they are settled
	always @(negedge clk) begin : watch
		logic [EW-1:0] expect_ev;
		logic          found;
		if (!rst_n) begin
			err_count    = 0;
			disp_total   = 0;
			commit_total = 0;
			cur_seed     = `PHOLD_SEED_RST;
			cur_end      = '0;
			running      = 1'b0;
			gvt_armed    = 1'b0;
			gvt_passed   = 1'b0;
			last_gvt     = '0;
			for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
				pending[c] = 1'b0;
			end
			model_q.delete();
		end else begin
			if (cfg_wr && cfg_addr == REG_SEED) begin
				cur_seed = cfg_wdata;
			end
			if (cfg_wr && cfg_addr == REG_END_TIME) begin
				cur_end = cfg_wdata;
			end
			if (cfg_wr && cfg_addr == REG_CTRL && cfg_wdata[0] && !running) begin
				begin_run();
			end

			if (running && gvt_armed) begin
				if (gvt < last_gvt) begin
					flag_error($sformatf("GVT fell from %0d to %0d", last_gvt, gvt));
				end
				if (gvt > cur_end) begin
					gvt_passed = 1'b1;
				end
			end
			last_gvt = gvt;

			if (disp_vld && commit_vld) begin
				flag_error("dispatch and commit in the same cycle");
			end

			if (disp_vld) begin
				disp_total++;
				run_disp++;
				if (!running) begin
					flag_error("dispatch outside a run");
				end
				if (model_q.size() == 0) begin
					flag_error("dispatch while the model queue is empty");
				end else if (disp_time != earliest_time()) begin
					flag_error($sformatf("dispatch time %0d, expected %0d",
						disp_time, earliest_time()));
				end
				found = 1'b0;
				for (int i = 0; i < model_q.size() && !found; i++) begin
					if (model_q[i] == {disp_lp, disp_time}) begin
						model_q.delete(i);
						found = 1'b1;
					end
				end
				if (!found) begin
					flag_error($sformatf("LP %0d has no event at time %0d", disp_lp, disp_time));
				end
				if (gvt > disp_time) begin
					flag_error($sformatf("GVT %0d above dispatch time %0d", gvt, disp_time));
				end
				if (pending[disp_core]) begin
					flag_error($sformatf("dispatch to busy core %0d", disp_core));
				end
				pending[disp_core]   = 1'b1;
				held_lp[disp_core]   = disp_lp;
				held_time[disp_core] = disp_time;
				gvt_armed            = 1'b1;
			end

			if (commit_vld) begin
				commit_total++;
				run_commit++;
				if (!pending[commit_core]) begin
					flag_error($sformatf("commit from core %0d without an event", commit_core));
				end else begin
					expect_ev = next_event(cur_seed, held_lp[commit_core],
						held_time[commit_core]);
					if ({commit_lp, commit_time} != expect_ev) begin
						flag_error($sformatf("core %0d commit LP %0d time %0d, expected LP %0d time %0d",
							commit_core, commit_lp, commit_time,
							expect_ev[EW-1:`PHOLD_TIME_W], expect_ev[`PHOLD_TIME_W-1:0]));
					end
					model_q.push_back(expect_ev);
				end
				pending[commit_core] = 1'b0;
			end

			if (rtn_vld) begin
				if (!running) begin
					flag_error("rtn_vld outside a run or longer than one cycle");
				end else begin
					if (!gvt_passed) begin
						flag_error($sformatf("rtn_vld before GVT passed end time %0d", cur_end));
					end
					if (run_disp != run_commit) begin
						flag_error($sformatf("rtn_vld with %0d dispatches and %0d commits",
							run_disp, run_commit));
					end
					running = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/phold_tb.sv
`default_nettype none

`include "phold_defs.svh"

module phold_tb import phold_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 8;

	logic                     clk;
	logic                     rst_n;
	logic                     cfg_wr;
	logic [1:0]               cfg_addr;
	logic [15:0]              cfg_wdata;
	logic [15:0]              cfg_rdata;
	logic [`PHOLD_TIME_W-1:0] gvt;
	logic                     rtn_vld;
	logic                     disp_vld;
	logic [`PHOLD_CORE_W-1:0] disp_core;
	logic [`PHOLD_LP_W-1:0]   disp_lp;
	logic [`PHOLD_TIME_W-1:0] disp_time;
	logic                     commit_vld;
	logic [`PHOLD_CORE_W-1:0] commit_core;
	logic [`PHOLD_LP_W-1:0]   commit_lp;
	logic [`PHOLD_TIME_W-1:0] commit_time;
	int                       chk_errors;
	int                       disp_total;
	int                       commit_total;
	int                       reg_errors = 0;
	int                       limit_cycles = 0;
	logic [15:0]              rng;
	logic [15:0]              end_a;
	logic [15:0]              end_b;
	logic [15:0]              seed_b;

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	phold_engine dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.gvt         (gvt),
		.rtn_vld     (rtn_vld),
		.disp_vld    (disp_vld),
		.disp_core   (disp_core),
		.disp_lp     (disp_lp),
		.disp_time   (disp_time),
		.commit_vld  (commit_vld),
		.commit_core (commit_core),
		.commit_lp   (commit_lp),
		.commit_time (commit_time)
	);

	phold_checker u_check (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.gvt          (gvt),
		.rtn_vld      (rtn_vld),
		.disp_vld     (disp_vld),
		.disp_core    (disp_core),
		.disp_lp      (disp_lp),
		.disp_time    (disp_time),
		.commit_vld   (commit_vld),
		.commit_core  (commit_core),
		.commit_lp    (commit_lp),
		.commit_time  (commit_time),
		.err_count    (chk_errors),
		.disp_total   (disp_total),
		.commit_total (commit_total)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] v);
		lfsr_next = v[0] ? ((v >> 1) ^ `PHOLD_LFSR_MASK) : (v >> 1);
	endfunction

	// One LFSR step per bit, LSB first out
	task automatic draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_next(rng);
			val = {val[14:0], rng[0]};
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clk);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wr    <= 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		data = cfg_rdata;                   // Combinational read, settled mid cycle
	endtask

	task automatic expect_reg(input logic [1:0] addr, input logic [15:0] exp, input string what);
		logic [15:0] val;
		read_reg(addr, val);
		if (val !== exp) begin
			reg_errors++;
			$display("ERR %0t: %s read 0x%04h, expected 0x%04h", $time, what, val, exp);
		end
	endtask

	// Start a run and follow the status bit until the done pulse
	task automatic run_once(input int run_no);
		logic seen_busy;
		logic done;
		seen_busy = 1'b0;
		done      = 1'b0;
		write_reg(REG_CTRL, 16'h0001);
		@(posedge clk);
		cfg_addr <= REG_STATUS;
		for (int i = 0; i < 4 && !seen_busy; i++) begin
			@(negedge clk);
			seen_busy = cfg_rdata[0];
		end
		if (!seen_busy) begin
			reg_errors++;
			$display("ERR %0t: run %0d status never showed busy", $time, run_no);
		end
		while (seen_busy && !done) begin
			@(negedge clk);
			if (!cfg_rdata[0]) begin
				reg_errors++;
				$display("ERR %0t: run %0d busy dropped before rtn_vld", $time, run_no);
				seen_busy = 1'b0;
			end else if (rtn_vld) begin
				done = 1'b1;
			end
		end
		@(negedge clk);
		if (cfg_rdata[0]) begin
			reg_errors++;
			$display("ERR %0t: run %0d still busy after rtn_vld", $time, run_no);
		end
	endtask

	initial begin : main
		logic [15:0] val;
		rst_n     <= 1'b0;
		cfg_wr    <= 1'b0;
		cfg_addr  <= '0;
		cfg_wdata <= '0;
		rng = 16'(97988);
		draw_bits(5, val);
		end_a = 16'd24 + val;
		draw_bits(5, val);
		end_b = 16'd24 + val;
		draw_bits(16, seed_b);
		if (seed_b == '0 || seed_b == `PHOLD_SEED_RST) begin
			seed_b = seed_b ^ 16'h5A5A;
		end
		limit_cycles = 40 * `PHOLD_NUM_LP * (int'(end_a) + int'(end_b));
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		expect_reg(REG_SEED, `PHOLD_SEED_RST, "seed after reset");
		write_reg(REG_END_TIME, end_a);
		expect_reg(REG_END_TIME, end_a, "end time of run 1");
		run_once(1);

		write_reg(REG_SEED, seed_b);
		write_reg(REG_END_TIME, end_b);
		expect_reg(REG_SEED, seed_b, "seed of run 2");
		expect_reg(REG_END_TIME, end_b, "end time of run 2");
		run_once(2);

		repeat (4) @(posedge clk);
		$display("Checks done: %0d checker errors, %0d register errors, %0d dispatches, %0d commits",
			chk_errors, reg_errors, disp_total, commit_total);
		if (chk_errors == 0 && reg_errors == 0 && disp_total > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the runs did not finish within %0d cycles", limit_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
